/* include/linear_cfg.svh */
`ifndef LINEAR_CFG_SVH
`define LINEAR_CFG_SVH

// Layer shape
`define LIN_IN_FEATURES  8
`define LIN_OUT_FEATURES 4

// Elements per data beat, also per weight beat
`define LIN_IN_PAR       2

// Input data, Q4.4
`define LIN_X_W          8
`define LIN_X_FRAC       4

// Weights, Q4.4
`define LIN_W_W          8
`define LIN_W_FRAC       4

// Bias, Q4.4
`define LIN_B_W          8
`define LIN_B_FRAC       4

// Accumulator carries data plus weight fraction bits
`define LIN_ACC_W        20

// Result, Q8.4
`define LIN_Y_W          12
`define LIN_Y_FRAC       4

`endif

/* rtl/linear_pkg.sv */
`include "linear_cfg.svh"

package linear_pkg;

  // Beat counts
  localparam int LIN_X_BEATS  = `LIN_IN_FEATURES / `LIN_IN_PAR;
  localparam int LIN_W_BEATS  = `LIN_OUT_FEATURES * LIN_X_BEATS;
  localparam int LIN_X_IW     = $clog2(LIN_X_BEATS);
  localparam int LIN_W_AW     = $clog2(LIN_W_BEATS);

  // Product fraction, kept through accumulation
  localparam int LIN_ACC_FRAC = `LIN_X_FRAC + `LIN_W_FRAC;

  typedef logic signed [`LIN_X_W-1:0]   x_elem_t;
  typedef logic signed [`LIN_W_W-1:0]   w_elem_t;
  typedef logic signed [`LIN_B_W-1:0]   b_elem_t;
  typedef logic signed [`LIN_ACC_W-1:0] acc_t;
  typedef logic signed [`LIN_Y_W-1:0]   y_elem_t;

  typedef struct packed {
    x_elem_t [`LIN_IN_PAR-1:0] elem;
  } x_beat_t;

  // Consecutive elements of one weight row
  typedef struct packed {
    w_elem_t [`LIN_IN_PAR-1:0] elem;
  } w_beat_t;

  // Indexed [output feature][element of data beat]
  typedef struct packed {
    w_elem_t [`LIN_OUT_FEATURES-1:0][`LIN_IN_PAR-1:0] w;
  } w_block_t;

  typedef struct packed {
    b_elem_t [`LIN_OUT_FEATURES-1:0] b;
  } b_vec_t;

  typedef struct packed {
    acc_t [`LIN_OUT_FEATURES-1:0] s;
  } acc_vec_t;

  typedef struct packed {
    y_elem_t [`LIN_OUT_FEATURES-1:0] y;
  } y_vec_t;

  typedef enum logic [1:0] {
    S_LOAD_W,
    S_LOAD_B,
    S_RUN
  } lin_state_e;

endpackage

/* rtl/linear_ctrl.sv */
module linear_ctrl (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic                            i_w_valid,
  input  logic                            i_b_valid,
  input  logic                            i_x_valid,
  input  logic                            i_y_ready,
  input  logic                            i_reload,
  input  logic                            out_full,
  output logic                            o_w_ready,
  output logic                            o_b_ready,
  output logic                            o_x_ready,
  output logic                            w_we,
  output logic [linear_pkg::LIN_W_AW-1:0] w_addr,
  output logic                            b_we,
  output logic [linear_pkg::LIN_X_IW-1:0] x_idx,
  output logic                            mac_en,
  output logic                            mac_last,
  output logic                            out_load
);
  import linear_pkg::*;

  lin_state_e          state;
  logic [LIN_W_AW-1:0] w_cnt;
  logic [LIN_X_IW-1:0] x_cnt;
  logic                w_done;
  logic                x_last;
  logic                out_stall;
  logic                reload_go;

  assign w_done = (w_cnt == LIN_W_AW'(LIN_W_BEATS - 1));
  assign x_last = (x_cnt == LIN_X_IW'(LIN_X_BEATS - 1));

  // Last beat of a vector waits while the result register cannot drain
  assign out_stall = x_last && out_full && !i_y_ready;

  // Reload is taken only between vectors
  assign reload_go = (state == S_RUN) && (x_cnt == '0) && i_reload;

  assign o_w_ready = (state == S_LOAD_W);
  assign o_b_ready = (state == S_LOAD_B);
  assign o_x_ready = (state == S_RUN) && !reload_go && !out_stall;

  assign w_we     = i_w_valid && o_w_ready;
  assign w_addr   = w_cnt;
  assign b_we     = i_b_valid && o_b_ready;
  assign x_idx    = x_cnt;
  assign mac_en   = i_x_valid && o_x_ready;
  assign mac_last = mac_en && x_last;
  assign out_load = mac_last;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= S_LOAD_W;
      w_cnt <= '0;
      x_cnt <= '0;
    end else begin
      case (state)
        S_LOAD_W: begin
          if (w_we) begin
            w_cnt <= w_done ? '0 : w_cnt + 1'b1;
            if (w_done) begin
              state <= S_LOAD_B;
            end
          end
        end
        S_LOAD_B: begin
          if (b_we) begin
            state <= S_RUN;
            x_cnt <= '0;
          end
        end
        S_RUN: begin
          if (reload_go) begin
            state <= S_LOAD_W;
            w_cnt <= '0;
          end else if (mac_en) begin
            x_cnt <= x_last ? '0 : x_cnt + 1'b1;
          end
        end
        default: begin
          state <= S_LOAD_W;
        end
      endcase
    end
  end

  // Weight loading and data streaming never overlap
  a_load_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
    w_we |-> (x_idx == '0));

  // The next vector starts at beat zero
  a_last_wrap: assert property (@(posedge clk) disable iff (!i_arst_n)
    mac_last |=> (x_idx == '0));

endmodule

/* rtl/weight_store.sv */
`include "linear_cfg.svh"

module weight_store (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic                            w_we,
  input  logic [linear_pkg::LIN_W_AW-1:0] w_addr,
  input  linear_pkg::w_beat_t             i_w,
  input  logic [linear_pkg::LIN_X_IW-1:0] x_idx,
  output linear_pkg::w_block_t            o_block
);
  import linear_pkg::*;

  // Row-major beats, address = row * LIN_X_BEATS + beat in row
  w_beat_t mem [LIN_W_BEATS];

  // Cleared so an unloaded store reads as zero weights
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int a = 0; a < LIN_W_BEATS; a++) begin
        mem[a] <= '0;
      end
    end else if (w_we) begin
      mem[w_addr] <= i_w;
    end
  end

  // Transposed read
  // Beat x_idx of every row lines up with data beat x_idx, so picking that
  // beat from each row gives the column block for all output features
  always_comb begin
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      o_block.w[o] = mem[o * LIN_X_BEATS + int'(x_idx)].elem;
    end
  end

endmodule

/* rtl/bias_store.sv */
`include "linear_cfg.svh"

module bias_store (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  b_we,
  input  linear_pkg::b_vec_t    i_b,
  output linear_pkg::acc_vec_t  o_b_acc
);
  import linear_pkg::*;

  // Align bias binary point with the accumulator
  localparam int B_SHIFT = LIN_ACC_FRAC - `LIN_B_FRAC;

  b_vec_t b_reg;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      b_reg <= '0;
    end else if (b_we) begin
      b_reg <= i_b;
    end
  end

  // Sign extend first, then shift up to the accumulator fraction
  always_comb begin
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      o_b_acc.s[o] = acc_t'(b_reg.b[o]) <<< B_SHIFT;
    end
  end

endmodule

/* rtl/mac_array.sv */
`include "linear_cfg.svh"

module mac_array (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  mac_en,
  input  logic                  mac_last,
  input  linear_pkg::x_beat_t   i_x,
  input  linear_pkg::w_block_t  i_block,
  output linear_pkg::acc_vec_t  o_sum
);
  import linear_pkg::*;

  acc_vec_t acc;
  acc_vec_t beat_sum;

  // Dot product of this data beat with each output feature's column slice
  always_comb begin
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      beat_sum.s[o] = '0;
      for (int p = 0; p < `LIN_IN_PAR; p++) begin
        // Operands widened first so the product is a signed full-width multiply
        beat_sum.s[o] = beat_sum.s[o] + acc_t'(i_x.elem[p]) * acc_t'(i_block.w[o][p]);
      end
    end
  end

  // Running sum including the current beat
  // On the last beat this is the finished dot product
  always_comb begin
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      o_sum.s[o] = acc.s[o] + beat_sum.s[o];
    end
  end

  // Clears as the finished sum is handed to the output stage
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      acc <= '0;
    end else if (mac_en) begin
      if (mac_last) begin
        acc <= '0;
      end else begin
        acc <= o_sum;
      end
    end
  end

endmodule

/* rtl/output_cast.sv */
`include "linear_cfg.svh"

module output_cast (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  out_load,
  input  linear_pkg::acc_vec_t  i_sum,
  input  linear_pkg::acc_vec_t  i_b_acc,
  input  logic                  i_y_ready,
  output linear_pkg::y_vec_t    o_y,
  output logic                  o_y_valid,
  output logic                  out_full
);
  import linear_pkg::*;

  localparam int R_SHIFT = LIN_ACC_FRAC - `LIN_Y_FRAC;
  // Two guard bits for the bias add and the rounding constant
  localparam int WIDE_W  = `LIN_ACC_W + 2;

  typedef logic signed [WIDE_W-1:0] wide_t;

  localparam wide_t HALF  = wide_t'(2 ** (R_SHIFT - 1));
  localparam wide_t Y_MAX = wide_t'(2 ** (`LIN_Y_W - 1) - 1);
  localparam wide_t Y_MIN = -Y_MAX - wide_t'(1);

  y_vec_t y_next;
  logic   y_valid;

  // Bias add, round half up, saturate
  always_comb begin
    wide_t wide;
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      wide = wide_t'(i_sum.s[o]) + wide_t'(i_b_acc.s[o]) + HALF;
      wide = wide >>> R_SHIFT;
      if (wide > Y_MAX) begin
        y_next.y[o] = y_elem_t'(Y_MAX);
      end else if (wide < Y_MIN) begin
        y_next.y[o] = y_elem_t'(Y_MIN);
      end else begin
        y_next.y[o] = y_elem_t'(wide);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      o_y <= y_next;
    end
  end

  // A load in the accepting cycle keeps the register full
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      y_valid <= 1'b0;
    end else if (out_load) begin
      y_valid <= 1'b1;
    end else if (i_y_ready) begin
      y_valid <= 1'b0;
    end
  end

  assign o_y_valid = y_valid;
  assign out_full  = y_valid;

  // Controller must hold off the last beat while a result is stalled
  a_y_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_y_valid && !i_y_ready) |=> (o_y_valid && $stable(o_y)));

endmodule

/* rtl/fixed_linear_top.sv */
module fixed_linear_top (
  input  logic                 clk,
  input  logic                 i_arst_n,

  input  linear_pkg::w_beat_t  i_w,
  input  logic                 i_w_valid,
  output logic                 o_w_ready,

  input  linear_pkg::b_vec_t   i_b,
  input  logic                 i_b_valid,
  output logic                 o_b_ready,

  input  linear_pkg::x_beat_t  i_x,
  input  logic                 i_x_valid,
  output logic                 o_x_ready,

  output linear_pkg::y_vec_t   o_y,
  output logic                 o_y_valid,
  input  logic                 i_y_ready,

  input  logic                 i_reload
);
  import linear_pkg::*;

  logic                w_we;
  logic [LIN_W_AW-1:0] w_addr;
  logic                b_we;
  logic [LIN_X_IW-1:0] x_idx;
  logic                mac_en;
  logic                mac_last;
  logic                out_load;
  logic                out_full;
  w_block_t            w_block;
  acc_vec_t            acc_sum;
  acc_vec_t            b_acc;

  linear_ctrl u_ctrl (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_w_valid (i_w_valid),
    .i_b_valid (i_b_valid),
    .i_x_valid (i_x_valid),
    .i_y_ready (i_y_ready),
    .i_reload  (i_reload),
    .out_full  (out_full),
    .o_w_ready (o_w_ready),
    .o_b_ready (o_b_ready),
    .o_x_ready (o_x_ready),
    .w_we      (w_we),
    .w_addr    (w_addr),
    .b_we      (b_we),
    .x_idx     (x_idx),
    .mac_en    (mac_en),
    .mac_last  (mac_last),
    .out_load  (out_load)
  );

  // Row-major in, column block out for the current data beat
  weight_store u_weights (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .w_we     (w_we),
    .w_addr   (w_addr),
    .i_w      (i_w),
    .x_idx    (x_idx),
    .o_block  (w_block)
  );

  bias_store u_bias (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .b_we     (b_we),
    .i_b      (i_b),
    .o_b_acc  (b_acc)
  );

  mac_array u_mac (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .mac_en   (mac_en),
    .mac_last (mac_last),
    .i_x      (i_x),
    .i_block  (w_block),
    .o_sum    (acc_sum)
  );

  output_cast u_out (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .out_load  (out_load),
    .i_sum     (acc_sum),
    .i_b_acc   (b_acc),
    .i_y_ready (i_y_ready),
    .o_y       (o_y),
    .o_y_valid (o_y_valid),
    .out_full  (out_full)
  );

endmodule

/* tests/tb_fixed_linear.sv */
`include "linear_cfg.svh"

module tb_fixed_linear;
  import linear_pkg::*;

  logic        clk;
  logic        i_arst_n;
  w_beat_t     i_w;
  logic        i_w_valid;
  logic        o_w_ready;
  b_vec_t      i_b;
  logic        i_b_valid;
  logic        o_b_ready;
  x_beat_t     i_x;
  logic        i_x_valid;
  logic        o_x_ready;
  y_vec_t      o_y;
  logic        o_y_valid;
  logic        i_y_ready;
  logic        i_reload;

  logic [2:0]  readies;
  logic        x_last_drv;
  logic [31:0] lfsr;
  int          errors;
  int          timeouts;
  int          w_seen;
  int          drain_t;

  // Reference layer, indexed [output][input]
  int          w_mdl [`LIN_OUT_FEATURES][`LIN_IN_FEATURES];
  int          b_mdl [`LIN_OUT_FEATURES];
  int          x_mdl [`LIN_IN_FEATURES];
  y_vec_t      exp_q [$];
  y_vec_t      exp_head;
  int          exp_cnt;

  fixed_linear_top uut (.*);

  always #2 clk = ~clk;

  assign readies = {o_x_ready, o_b_ready, o_w_ready};

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Q4.4 times Q4.4 gives Q.8, bias moved up 4 bits, then round half up to Q.4
  function automatic y_vec_t model_out();
    y_vec_t y;
    int     acc;
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      acc = b_mdl[o] * 16;
      for (int i = 0; i < `LIN_IN_FEATURES; i++) begin
        acc += x_mdl[i] * w_mdl[o][i];
      end
      acc = (acc + 8) >>> 4;
      if (acc > 2047) begin
        acc = 2047;
      end else if (acc < -2048) begin
        acc = -2048;
      end
      y.y[o] = acc[11:0];
    end
    return y;
  endfunction

  task automatic refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
  endtask

  // Ready is looked at on the falling edge, the beat moves on the next rising edge
  task automatic await_accept(input int which, output bit ok);
    int t;
    t = 0;
    @(negedge clk);
    while (!readies[which] && t < 200) begin
      @(negedge clk);
      t++;
    end
    ok = readies[which];
    if (!ok) begin
      timeouts++;
      $display("no handshake on stream %0d within 200 cycles", which);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic load_layer(input bit rnd, input logic [7:0] w_fix, input logic [7:0] b_fix);
    bit ok;
    for (int r = 0; r < `LIN_OUT_FEATURES; r++) begin
      for (int k = 0; k < LIN_X_BEATS; k++) begin
        for (int p = 0; p < `LIN_IN_PAR; p++) begin
          i_w.elem[p] = rnd ? w_elem_t'(rand_bits(8)) : w_elem_t'(w_fix);
          w_mdl[r][k*`LIN_IN_PAR+p] = int'(i_w.elem[p]);
        end
        i_w_valid = 1'b1;
        await_accept(0, ok);
      end
    end
    i_w_valid = 1'b0;
    for (int o = 0; o < `LIN_OUT_FEATURES; o++) begin
      i_b.b[o] = rnd ? b_elem_t'(rand_bits(8)) : b_elem_t'(b_fix);
      b_mdl[o] = int'(i_b.b[o]);
    end
    i_b_valid = 1'b1;
    await_accept(1, ok);
    i_b_valid = 1'b0;
  endtask

  // With lit set, every output element is expected to be y_lit
  task automatic send_vector(input bit rnd, input logic [7:0] x_fix, input bit lit,
                             input logic [11:0] y_lit);
    bit     ok;
    y_vec_t e;
    for (int i = 0; i < `LIN_IN_FEATURES; i++) begin
      x_mdl[i] = rnd ? int'(x_elem_t'(rand_bits(8))) : int'(x_elem_t'(x_fix));
    end
    for (int k = 0; k < LIN_X_BEATS; k++) begin
      for (int p = 0; p < `LIN_IN_PAR; p++) begin
        i_x.elem[p] = x_elem_t'(x_mdl[k*`LIN_IN_PAR+p]);
      end
      i_x_valid  = 1'b1;
      x_last_drv = (k == LIN_X_BEATS - 1);
      await_accept(2, ok);
    end
    i_x_valid  = 1'b0;
    x_last_drv = 1'b0;
    if (ok) begin
      if (lit) begin
        e = y_vec_t'({`LIN_OUT_FEATURES{y_lit}});
      end else begin
        e = model_out();
      end
      exp_q.push_back(e);
      refresh_head();
    end
  endtask

  task automatic pulse_reload();
    i_reload = 1'b1;
    @(posedge clk);
    #1;
    i_reload = 1'b0;
  endtask

  // Pops after the compare, which sees the old head
  always @(posedge clk) begin
    if (i_arst_n && o_y_valid && i_y_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // Weight beats since the layer was last running
  always @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      w_seen <= 0;
    end else if (i_w_valid && o_w_ready) begin
      w_seen <= w_seen + 1;
    end else if (o_x_ready) begin
      w_seen <= 0;
    end
  end

  a_reset_state: assert property (@(posedge clk) disable iff (!i_arst_n)
    $rose(i_arst_n) |-> (o_w_ready && !o_b_ready && !o_x_ready && !o_y_valid))
    else begin
      errors++;
      $display("ready and valid outputs are wrong right after reset");
    end

  a_bias_turn: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_b_ready |-> (w_seen == LIN_W_BEATS && !o_w_ready))
    else begin
      errors++;
      $display("bias stream opened before all weight beats were taken");
    end

  a_run_open: assert property (@(posedge clk) disable iff (!i_arst_n)
    $fell(o_b_ready) |-> o_x_ready)
    else begin
      errors++;
      $display("data stream did not open after the bias beat");
    end

  a_y_expected: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_y_valid && i_y_ready) |-> (exp_cnt > 0))
    else begin
      errors++;
      $display("result accepted while no result was expected");
    end

  a_y_value: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_y_valid && i_y_ready && exp_cnt > 0) |-> (o_y == exp_head))
    else begin
      errors++;
      $display("error o_y: got %h expected %h", $sampled(o_y), $sampled(exp_head));
    end

  a_y_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_y_valid && !i_y_ready) |=> (o_y_valid && $stable(o_y)))
    else begin
      errors++;
      $display("held result changed or dropped before it was accepted");
    end

  a_x_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_x_valid && x_last_drv && o_y_valid && !i_y_ready) |-> !o_x_ready)
    else begin
      errors++;
      $display("last data beat accepted while the result register was held");
    end

  a_reload: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_reload && !o_w_ready && !o_b_ready) |=> o_w_ready)
    else begin
      errors++;
      $display("reload pulse did not return to weight loading");
    end

  initial begin
    clk        = 1'b0;
    i_arst_n   = 1'b0;
    i_w        = '0;
    i_w_valid  = 1'b0;
    i_b        = '0;
    i_b_valid  = 1'b0;
    i_x        = '0;
    i_x_valid  = 1'b0;
    i_y_ready  = 1'b1;
    i_reload   = 1'b0;
    x_last_drv = 1'b0;
    lfsr       = 32'h19b3;
    errors     = 0;
    timeouts   = 0;
    exp_cnt    = 0;
    exp_head   = '0;
    repeat (8) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    @(posedge clk);
    #1;

    load_layer(1'b1, 8'h00, 8'h00);
    repeat (12) send_vector(1'b1, 8'h00, 1'b0, 12'h000);

    // Sink stalls while three vectors stream in
    i_y_ready = 1'b0;
    fork
      repeat (3) send_vector(1'b1, 8'h00, 1'b0, 12'h000);
      begin
        repeat (24) @(posedge clk);
        #1;
        i_y_ready = 1'b1;
      end
    join

    // Extreme operands, bias of +1.0
    pulse_reload();
    load_layer(1'b0, 8'h80, 8'h10);
    send_vector(1'b0, 8'h80, 1'b1, 12'h7ff);
    send_vector(1'b0, 8'h7f, 1'b1, 12'h800);

    pulse_reload();
    load_layer(1'b1, 8'h00, 8'h00);
    repeat (10) send_vector(1'b1, 8'h00, 1'b0, 12'h000);

    drain_t = 0;
    while (exp_cnt > 0 && drain_t < 500) begin
      @(posedge clk);
      drain_t++;
    end
    if (exp_cnt > 0) begin
      timeouts++;
      $display("%0d results never arrived", exp_cnt);
    end

    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
rtl/linear_pkg.sv
rtl/linear_ctrl.sv
rtl/weight_store.sv
rtl/bias_store.sv
rtl/mac_array.sv
rtl/output_cast.sv
rtl/fixed_linear_top.sv
tests/tb_fixed_linear.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fixed_linear
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
